/* build.f */
game_pkg.sv
field_if.sv
game_timebase.sv
player_ctrl.sv
bullet_unit.sv
enemy_field.sv
game_fsm.sv
game_top.sv
game_sva.sv
game_tb.sv

/* bullet_unit.sv */
`timescale 1ns/1ps

module bullet_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                bullet_tick,
    input  logic                running,
    input  logic                joy_fire,
    input  logic [9:0]          joy_x,
    input  logic [9:0]          joy_y,
    input  logic [9:0]          player_x,
    input  logic [9:0]          player_y,
    field_if.bullet_side        field,
    output logic                bullet_active,
    output logic [9:0]          bullet_x,
    output logic [9:0]          bullet_y,
    output logic [7:0]          score
);

    localparam int XW = game_pkg::ENEMY_X_W;
    localparam int CW = game_pkg::COORD_W;

    int                              dx, dy;
    logic                            fire_now;
    logic                            in_box;
    logic signed [3:0]               vx, vy;
    logic [game_pkg::N_ENEMIES-1:0]  hits;

    // sign(d) * ((|d| * speed) >> 9), so at most +-5 per tick
    function automatic logic signed [3:0] scale_vel(input int d);
        int s;
        s = (((d < 0) ? -d : d) * game_pkg::MAX_BULLET_SPEED) >> 9;
        if (d < 0)
            s = -s;
        return s[3:0];
    endfunction

    // ====================================================================
    // aiming and dead zone
    // ====================================================================
    assign dx = int'(joy_x) - game_pkg::JOY_CENTER;
    assign dy = int'(joy_y) - game_pkg::JOY_CENTER;
    assign fire_now = running && joy_fire && !bullet_active &&
                      (((dx * dx + dy * dy) >> 8) >
                       ((game_pkg::DEAD_ZONE * game_pkg::DEAD_ZONE) >> 8));

    assign in_box = (bullet_x >= game_pkg::MARGIN) &&
                    (bullet_x <= game_pkg::SCREEN_W - game_pkg::MARGIN) &&
                    (bullet_y >= game_pkg::MARGIN) &&
                    (bullet_y <= game_pkg::SCREEN_H - game_pkg::MARGIN);

    // bullet against every live enemy slot
    always_comb begin
        for (int i = 0; i < game_pkg::N_ENEMIES; i++) begin
            hits[i] = field.enemy_active[i] &&
                      game_pkg::overlap(int'(bullet_x), int'(bullet_y),
                                        game_pkg::BULLET_W, game_pkg::BULLET_H,
                                        int'($signed(field.enemy_x[i*XW +: XW])),
                                        int'(field.enemy_y[i*CW +: CW]),
                                        game_pkg::OBJ_SIZE, game_pkg::OBJ_SIZE);
        end
    end

    // ====================================================================
    // control state and score
    // ====================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bullet_active  <= 1'b0;
            field.hit_mask <= '0;
            score          <= '0;
        end else if (!running) begin
            bullet_active  <= 1'b0;
            field.hit_mask <= '0;
            score          <= '0;
        end else if (bullet_tick) begin
            if (fire_now) begin
                bullet_active  <= 1'b1;
                field.hit_mask <= '0;
            end else if (bullet_active) begin
                if (|hits) begin
                    bullet_active  <= 1'b0;
                    field.hit_mask <= field.hit_mask | hits;
                    if (score < game_pkg::WIN_SCORE)
                        score <= score + 8'd1;   // saturates at win
                end else if (!in_box) begin
                    bullet_active <= 1'b0;
                end
            end
        end
    end

    // position and velocity
    always_ff @(posedge clk) begin
        if (bullet_tick) begin
            if (fire_now) begin
                bullet_x <= player_x + game_pkg::BULLET_X_OFS[CW-1:0];
                bullet_y <= player_y;
                vx       <= scale_vel(dx);
                vy       <= scale_vel(dy);
            end else if (bullet_active) begin
                bullet_x <= bullet_x + {{(CW-4){vx[3]}}, vx};   // wraps high when < 0
                bullet_y <= bullet_y + {{(CW-4){vy[3]}}, vy};
            end
        end
    end

endmodule

/* enemy_field.sv */
`timescale 1ns/1ps

module enemy_field (
    input  logic         clk,
    input  logic         rst,
    input  logic         enemy_tick,
    input  logic         running,
    input  logic [9:0]   lfsr,
    input  logic [9:0]   player_x,
    input  logic [9:0]   player_y,
    field_if.enemy_side  field,
    output logic [7:0]   health
);

    localparam int N  = game_pkg::N_ENEMIES;
    localparam int XW = game_pkg::ENEMY_X_W;
    localparam int CW = game_pkg::COORD_W;

    logic signed [XW-1:0] ex  [N];
    logic [CW-1:0]        ey  [N];
    logic signed [4:0]    edx [N];
    logic [N-1:0]         active;
    logic [N-1:0]         pl_hit;     // slot touches the player this tick
    logic [N-1:0]         leaving;
    int                   spawn_y;

    assign spawn_y = int'(lfsr) % game_pkg::SCREEN_H + game_pkg::OBJ_SIZE;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            pl_hit[i]  = active[i] && !field.hit_mask[i] &&
                         game_pkg::overlap(int'(ex[i]), int'(ey[i]),
                                           game_pkg::OBJ_SIZE, game_pkg::OBJ_SIZE,
                                           int'(player_x), int'(player_y),
                                           game_pkg::OBJ_SIZE, game_pkg::OBJ_SIZE);
            leaving[i] = (edx[i] > 0 && ex[i] > game_pkg::SPAWN_RIGHT) ||
                         (edx[i] < 0 && ex[i] < game_pkg::SPAWN_LEFT);
        end
    end

    // ====================================================================
    // slot occupancy and health
    // ====================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= '0;
            health <= game_pkg::HEALTH_INIT;
        end else if (!running) begin
            active <= '0;
            health <= game_pkg::HEALTH_INIT;
        end else if (enemy_tick) begin
            for (int i = 0; i < N; i++) begin
                if (field.hit_mask[i])
                    active[i] <= 1'b0;                      // shot down
                else if (active[i])
                    active[i] <= !(pl_hit[i] || leaving[i]);
                else
                    active[i] <= 1'b1;                      // respawn
            end
            if (|pl_hit)
                health <= (health >= game_pkg::HIT_DAMAGE) ?
                          health - game_pkg::HIT_DAMAGE : 8'd0;
        end
    end

    // motion, and a fresh start point for every empty slot
    always_ff @(posedge clk) begin
        if (enemy_tick) begin
            for (int i = 0; i < N; i++) begin
                if (active[i]) begin
                    ex[i] <= ex[i] + {{(XW-5){edx[i][4]}}, edx[i]};
                end else begin
                    ex[i]  <= lfsr[0] ? game_pkg::SPAWN_LEFT[XW-1:0] :
                                        game_pkg::SPAWN_RIGHT[XW-1:0];
                    edx[i] <= lfsr[0] ? 5'(game_pkg::ENEMY_SPEED) :
                                        5'(-game_pkg::ENEMY_SPEED);
                    ey[i]  <= spawn_y[CW-1:0];
                end
            end
        end
    end

    assign field.enemy_active = active;

    for (genvar g = 0; g < N; g++) begin : g_pack
        assign field.enemy_x[g*XW +: XW] = ex[g];
        assign field.enemy_y[g*CW +: CW] = ey[g];
    end

endmodule

/* field_if.sv */
`timescale 1ns/1ps

interface field_if;

    // enemy slots, packed per slot
    logic [game_pkg::N_ENEMIES-1:0]                     enemy_active;
    logic [game_pkg::N_ENEMIES*game_pkg::ENEMY_X_W-1:0] enemy_x;
    logic [game_pkg::N_ENEMIES*game_pkg::COORD_W-1:0]   enemy_y;

    logic [game_pkg::N_ENEMIES-1:0] hit_mask;   // level, held until next fire

    modport enemy_side (
        output enemy_active, enemy_x, enemy_y,
        input  hit_mask
    );

    modport bullet_side (
        input  enemy_active, enemy_x, enemy_y,
        output hit_mask
    );

endinterface

/* game_fsm.sv */
`timescale 1ns/1ps

module game_fsm (
    input  logic       clk,
    input  logic       rst,
    input  logic       joy_fire,
    input  logic       joy_back,
    input  logic       joy_restart,
    input  logic       btn_up,
    input  logic       btn_down,
    input  logic [7:0] score,
    input  logic [7:0] health,
    output logic [2:0] game_state,
    output logic       menu_sel,
    output logic       running
);

    logic [2:0] next_state;

    always_comb begin
        next_state = game_state;
        case (game_state)
            game_pkg::ST_MENU:
                if (joy_fire)
                    next_state = menu_sel ? game_pkg::ST_TUTORIAL : game_pkg::ST_RUNNING;
            game_pkg::ST_TUTORIAL:
                if (joy_back) next_state = game_pkg::ST_MENU;
            game_pkg::ST_RUNNING:
                if (score >= game_pkg::WIN_SCORE)
                    next_state = game_pkg::ST_WIN;      // win beats a same-cycle death
                else if (health == 8'd0)
                    next_state = game_pkg::ST_OVER;
            game_pkg::ST_OVER, game_pkg::ST_WIN:
                if (joy_restart) next_state = game_pkg::ST_MENU;
            default: next_state = game_pkg::ST_MENU;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state <= game_pkg::ST_MENU;
            menu_sel   <= 1'b0;
        end else begin
            game_state <= next_state;
            if (game_state == game_pkg::ST_MENU) begin
                if (btn_up)
                    menu_sel <= 1'b0;       // start game
                else if (btn_down)
                    menu_sel <= 1'b1;       // tutorial
            end
        end
    end

    assign running = (game_state == game_pkg::ST_RUNNING);

endmodule

/* game_pkg.sv */
package game_pkg;

    // ====================================================================
    // screen and object geometry
    // ====================================================================
    localparam int SCREEN_W     = 640;
    localparam int SCREEN_H     = 480;
    localparam int COORD_W      = 10;
    localparam int ENEMY_X_W    = 11;   // signed, enemies start off screen
    localparam int START_X      = 320;
    localparam int START_Y      = 240;
    localparam int STEP         = 5;
    localparam int MARGIN       = 5;
    localparam int OBJ_SIZE     = 20;   // player and enemy squares
    localparam int BULLET_W     = 5;
    localparam int BULLET_H     = 10;
    localparam int BULLET_X_OFS = 10;

    // joystick aiming
    localparam int JOY_CENTER       = 512;
    localparam int DEAD_ZONE        = 100;
    localparam int MAX_BULLET_SPEED = 5;

    // enemy field
    localparam int N_ENEMIES   = 10;
    localparam int ENEMY_SPEED = 10;
    localparam int SPAWN_LEFT  = -20;
    localparam int SPAWN_RIGHT = 660;

    localparam logic [7:0] HEALTH_INIT = 8'd50;
    localparam logic [7:0] HIT_DAMAGE  = 8'd5;
    localparam logic [7:0] WIN_SCORE   = 8'd10;

    // tick divisors, in clk cycles
    localparam int BULLET_DIV = 8;
    localparam int ENEMY_DIV  = 32;

    localparam logic [9:0] LFSR_SEED = 10'b1010101010;   // must not be all zero

    // game states
    localparam logic [2:0] ST_MENU     = 3'd0;
    localparam logic [2:0] ST_TUTORIAL = 3'd1;
    localparam logic [2:0] ST_RUNNING  = 3'd2;
    localparam logic [2:0] ST_OVER     = 3'd3;
    localparam logic [2:0] ST_WIN      = 3'd4;

    // box a (ax, ay, aw, ah) touches box b, edges inclusive on the near side
    function automatic logic overlap(input int ax, input int ay, input int aw, input int ah,
                                     input int bx, input int by, input int bw, input int bh);
        return (ax + aw >= bx) && (ax < bx + bw) && (ay + ah >= by) && (ay < by + bh);
    endfunction

endpackage

/* game_sva.sv */
`timescale 1ns/1ps

module game_sva (
    input logic       clk,
    input logic       rst,
    input logic       running,
    input logic       joy_fire,
    input logic       joy_back,
    input logic       joy_restart,
    input logic       key_w,
    input logic       key_a,
    input logic       key_s,
    input logic       key_d,
    input logic [9:0] joy_x,
    input logic [9:0] joy_y,
    input logic [2:0] game_state,
    input logic       menu_sel,
    input logic [9:0] player_x,
    input logic [9:0] player_y,
    input logic       bullet_active,
    input logic [9:0] bullet_x,
    input logic [9:0] bullet_y,
    input logic [7:0] score,
    input logic [7:0] health,
    input logic [game_pkg::N_ENEMIES-1:0] enemy_active
);

    int         fails = 0;   // failed assertions so far
    int         dx, dy;
    logic       aim_out;     // stick outside the dead zone
    logic [2:0] run_next;    // state expected after a running cycle

    assign dx = int'(joy_x) - game_pkg::JOY_CENTER;
    assign dy = int'(joy_y) - game_pkg::JOY_CENTER;
    assign aim_out = ((dx * dx + dy * dy) >> 8) >
                     ((game_pkg::DEAD_ZONE * game_pkg::DEAD_ZONE) >> 8);
    assign run_next = (score >= game_pkg::WIN_SCORE) ? game_pkg::ST_WIN :
                      (health == 8'd0) ? game_pkg::ST_OVER : game_pkg::ST_RUNNING;

    // ====================================================================
    // reset and menu
    // ====================================================================
    a_reset: assert property (@(posedge clk) $fell(rst) |->
        game_state == game_pkg::ST_MENU && score == 8'd0 && !bullet_active &&
        health == game_pkg::HEALTH_INIT &&
        player_x == 10'(game_pkg::START_X) && player_y == 10'(game_pkg::START_Y))
        else begin
            fails++;
            $error("[ERROR] after reset game_state 0x%0h score 0x%0h health 0x%0h x 0x%0h y 0x%0h",
                   game_state, score, health, player_x, player_y);
        end

    a_idle: assert property (@(posedge clk) disable iff (rst)
        !running |=> enemy_active == '0 && !bullet_active)
        else begin
            fails++;
            $error("[ERROR] enemy_active 0x%0h bullet_active 0x%0h outside a game",
                   enemy_active, bullet_active);
        end

    a_menu_fire: assert property (@(posedge clk) disable iff (rst)
        game_state == game_pkg::ST_MENU && joy_fire |=>
        game_state == ($past(menu_sel) ? game_pkg::ST_TUTORIAL : game_pkg::ST_RUNNING))
        else begin
            fails++;
            $error("[ERROR] game_state 0x%0h after menu fire, menu_sel 0x%0h",
                   game_state, menu_sel);
        end

    a_to_menu: assert property (@(posedge clk) disable iff (rst)
        (game_state == game_pkg::ST_TUTORIAL && joy_back) ||
        ((game_state == game_pkg::ST_WIN || game_state == game_pkg::ST_OVER) && joy_restart)
        |=> game_state == game_pkg::ST_MENU)
        else begin
            fails++;
            $error("[ERROR] game_state 0x%0h, expected menu 0x%0h", game_state,
                   game_pkg::ST_MENU);
        end

    // ====================================================================
    // movement and firing
    // ====================================================================
    a_up: assert property (@(posedge clk) disable iff (rst)
        running && $rose(key_w) |=> int'(player_y) == (($past(player_y) > game_pkg::MARGIN) ?
        int'($past(player_y)) - game_pkg::STEP : int'($past(player_y))))
        else begin
            fails++;
            $error("[ERROR] player_y 0x%0h after key w", player_y);
        end

    a_down: assert property (@(posedge clk) disable iff (rst)
        running && $rose(key_s) |=> int'(player_y) ==
        (($past(player_y) < game_pkg::SCREEN_H - game_pkg::MARGIN) ?
        int'($past(player_y)) + game_pkg::STEP : int'($past(player_y))))
        else begin
            fails++;
            $error("[ERROR] player_y 0x%0h after key s", player_y);
        end

    a_left: assert property (@(posedge clk) disable iff (rst)
        running && $rose(key_a) |=> int'(player_x) == (($past(player_x) > game_pkg::MARGIN) ?
        int'($past(player_x)) - game_pkg::STEP : int'($past(player_x))))
        else begin
            fails++;
            $error("[ERROR] player_x 0x%0h after key a", player_x);
        end

    a_right: assert property (@(posedge clk) disable iff (rst)
        running && $rose(key_d) |=> int'(player_x) ==
        (($past(player_x) < game_pkg::SCREEN_W - game_pkg::MARGIN) ?
        int'($past(player_x)) + game_pkg::STEP : int'($past(player_x))))
        else begin
            fails++;
            $error("[ERROR] player_x 0x%0h after key d", player_x);
        end

    a_fire: assert property (@(posedge clk) disable iff (rst)
        $rose(bullet_active) |-> $past(aim_out && joy_fire && running) &&
        int'(bullet_x) == int'($past(player_x)) + game_pkg::BULLET_X_OFS &&
        bullet_y == $past(player_y))
        else begin
            fails++;
            $error("[ERROR] bullet_x 0x%0h bullet_y 0x%0h at launch, joy 0x%0h 0x%0h",
                   bullet_x, bullet_y, joy_x, joy_y);
        end

    // ====================================================================
    // score, health and the end of a game
    // ====================================================================
    a_score: assert property (@(posedge clk) disable iff (rst)
        running && $past(running) |->
        score <= game_pkg::WIN_SCORE && score >= $past(score))
        else begin
            fails++;
            $error("[ERROR] score 0x%0h out of bounds", score);
        end

    a_health: assert property (@(posedge clk) disable iff (rst)
        running && $past(running) |->
        health <= $past(health) && health % game_pkg::HIT_DAMAGE == 8'd0)
        else begin
            fails++;
            $error("[ERROR] health 0x%0h rose or is off the damage step", health);
        end

    a_end: assert property (@(posedge clk) disable iff (rst)
        running |=> game_state == $past(run_next))
        else begin
            fails++;
            $error("[ERROR] game_state 0x%0h with score 0x%0h health 0x%0h",
                   game_state, score, health);
        end

    a_fresh: assert property (@(posedge clk) disable iff (rst)
        $rose(running) |-> score == 8'd0 && health == game_pkg::HEALTH_INIT)
        else begin
            fails++;
            $error("[ERROR] new game with score 0x%0h health 0x%0h", score, health);
        end

endmodule

/* game_tb.sv */
`timescale 1ns/1ps

module game_tb;

    logic       clk;
    logic       rst;
    logic       key_w, key_a, key_s, key_d;
    logic [9:0] joy_x, joy_y;
    logic       joy_fire, joy_back, joy_restart;
    logic       btn_up, btn_down;
    logic [2:0] game_state;
    logic       menu_sel;
    logic [9:0] player_x, player_y;
    logic       bullet_active;
    logic [9:0] bullet_x, bullet_y;
    logic [7:0] score, health;
    logic [game_pkg::N_ENEMIES-1:0] enemy_active;
    int         seed;

    game_top u_game_top (.*);

    bind game_top game_sva u_sva (.*);

    always #50 clk = ~clk;

    task automatic fail_now(input string reason);
        $display("TEST FAIL");
        $fatal(1, "%s", reason);
    endtask

    // bits are w a s d fire back restart up down
    task automatic pulse(input logic [8:0] b);
        @(posedge clk);
        {key_w, key_a, key_s, key_d, joy_fire, joy_back, joy_restart, btn_up, btn_down} <= b;
        @(posedge clk);
        {key_w, key_a, key_s, key_d, joy_fire, joy_back, joy_restart, btn_up, btn_down} <= '0;
    endtask

    // goals 0 to 4 are states, 5 is any game end, 6 a live bullet
    function automatic logic reached(input int goal);
        if (goal == 5)
            return game_state == game_pkg::ST_WIN || game_state == game_pkg::ST_OVER;
        else if (goal == 6)
            return bullet_active;
        else
            return game_state == goal[2:0];
    endfunction

    task automatic wait_for(input int goal, input int limit, input string what);
        int n;
        n = 0;
        while (!reached(goal) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!reached(goal))
            fail_now({"timed out waiting for ", what});
    endtask

    // any assertion failure ends the run
    always @(negedge clk) begin
        if (u_game_top.u_sva.fails != 0)
            fail_now("an assertion failed");
    end

    initial begin
        seed        = 32'h4645;
        clk         = 1'b0;
        rst         = 1'b1;
        {key_w, key_a, key_s, key_d} = 4'b0000;
        {joy_fire, joy_back, joy_restart, btn_up, btn_down} = 5'b00000;
        joy_x       = 10'(game_pkg::JOY_CENTER);
        joy_y       = 10'(game_pkg::JOY_CENTER);
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // ================================================================
        // menu, tutorial and start
        // ================================================================
        pulse(9'b000000001);                    // down picks the tutorial
        pulse(9'b000010000);
        wait_for(game_pkg::ST_TUTORIAL, 20, "tutorial");
        pulse(9'b000001000);                    // back
        wait_for(game_pkg::ST_MENU, 20, "menu after back");
        pulse(9'b000000010);
        pulse(9'b000010000);
        wait_for(game_pkg::ST_RUNNING, 20, "first game");

        // right, left, down, then up to the top border and one blocked press
        pulse(9'b000100000);
        pulse(9'b010000000);
        pulse(9'b001000000);
        repeat (49) pulse(9'b100000000);

        // stick inside the dead zone
        repeat (40) begin
            @(posedge clk);
            joy_fire <= 1'b1;
            joy_x    <= 10'(game_pkg::JOY_CENTER + $random(seed) % 60);
            joy_y    <= 10'(game_pkg::JOY_CENTER + $random(seed) % 60);
        end
        @(posedge clk);
        joy_x <= 10'(game_pkg::JOY_CENTER + 400 + $random(seed) % 100);
        joy_y <= 10'(game_pkg::JOY_CENTER);
        wait_for(6, 200, "first bullet");

        // shoot straight down from the top row until the game ends
        @(posedge clk);
        joy_x <= 10'(game_pkg::JOY_CENTER + $random(seed) % 8);
        joy_y <= 10'(1000 + $random(seed) % 20);
        wait_for(5, 2000000, "end of first game");
        @(posedge clk);
        joy_fire <= 1'b0;

        // ================================================================
        // restart, then a game lost to enemy contact
        // ================================================================
        pulse(9'b000000100);
        wait_for(game_pkg::ST_MENU, 20, "menu after restart");
        pulse(9'b000010000);
        wait_for(game_pkg::ST_RUNNING, 20, "second game");
        wait_for(5, 3000000, "end of second game");
        pulse(9'b000000100);
        wait_for(game_pkg::ST_MENU, 20, "menu after second restart");
        repeat (4) @(posedge clk);

        if (u_game_top.u_sva.fails == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            fail_now("assertion failures at end of run");
        end
    end

endmodule

/* game_timebase.sv */
`timescale 1ns/1ps

module game_timebase (
    input  logic       clk,
    input  logic       rst,
    output logic       bullet_tick,
    output logic       enemy_tick,
    output logic [9:0] lfsr
);

    logic [$clog2(game_pkg::BULLET_DIV)-1:0] bullet_cnt;
    logic [$clog2(game_pkg::ENEMY_DIV)-1:0]  enemy_cnt;

    // free running dividers, one-cycle strobe at wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bullet_cnt  <= '0;
            enemy_cnt   <= '0;
            bullet_tick <= 1'b0;
            enemy_tick  <= 1'b0;
        end else begin
            bullet_tick <= (bullet_cnt == game_pkg::BULLET_DIV - 1);
            enemy_tick  <= (enemy_cnt == game_pkg::ENEMY_DIV - 1);
            bullet_cnt  <= (bullet_cnt == game_pkg::BULLET_DIV - 1) ? '0 : bullet_cnt + 1'b1;
            enemy_cnt   <= (enemy_cnt == game_pkg::ENEMY_DIV - 1) ? '0 : enemy_cnt + 1'b1;
        end
    end

    // x^10 + x^7 + 1, steps once per enemy tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= game_pkg::LFSR_SEED;
        end else if (enemy_tick) begin
            lfsr <= {lfsr[8:0], lfsr[9] ^ lfsr[6]};
        end
    end

endmodule

/* game_top.sv */
`timescale 1ns/1ps

module game_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           key_w,
    input  logic                           key_a,
    input  logic                           key_s,
    input  logic                           key_d,
    input  logic [9:0]                     joy_x,
    input  logic [9:0]                     joy_y,
    input  logic                           joy_fire,
    input  logic                           joy_back,
    input  logic                           joy_restart,
    input  logic                           btn_up,
    input  logic                           btn_down,
    output logic [2:0]                     game_state,
    output logic                           menu_sel,
    output logic [9:0]                     player_x,
    output logic [9:0]                     player_y,
    output logic                           bullet_active,
    output logic [9:0]                     bullet_x,
    output logic [9:0]                     bullet_y,
    output logic [7:0]                     score,
    output logic [7:0]                     health,
    output logic [game_pkg::N_ENEMIES-1:0] enemy_active
);

    logic       bullet_tick;
    logic       enemy_tick;
    logic [9:0] lfsr;
    logic       running;

    field_if u_field ();

    assign enemy_active = u_field.enemy_active;

    game_timebase u_timebase (
        .clk         (clk),
        .rst         (rst),
        .bullet_tick (bullet_tick),
        .enemy_tick  (enemy_tick),
        .lfsr        (lfsr)
    );

    game_fsm u_fsm (
        .clk, .rst, .joy_fire, .joy_back, .joy_restart, .btn_up, .btn_down,
        .score, .health, .game_state, .menu_sel, .running
    );

    player_ctrl u_player (
        .clk, .rst, .running, .key_w, .key_a, .key_s, .key_d, .player_x, .player_y
    );

    bullet_unit u_bullet (
        .clk, .rst, .bullet_tick, .running, .joy_fire, .joy_x, .joy_y,
        .player_x, .player_y,
        .field         (u_field.bullet_side),
        .bullet_active, .bullet_x, .bullet_y, .score
    );

    enemy_field u_enemies (
        .clk, .rst, .enemy_tick, .running, .lfsr, .player_x, .player_y,
        .field  (u_field.enemy_side),
        .health
    );

endmodule

/* player_ctrl.sv */
`timescale 1ns/1ps

module player_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       running,
    input  logic       key_w,
    input  logic       key_a,
    input  logic       key_s,
    input  logic       key_d,
    output logic [9:0] player_x,
    output logic [9:0] player_y
);

    logic       prev_w, prev_a, prev_s, prev_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            player_x <= game_pkg::START_X[game_pkg::COORD_W-1:0];
            player_y <= game_pkg::START_Y[game_pkg::COORD_W-1:0];
            prev_w   <= 1'b0;
            prev_a   <= 1'b0;
            prev_s   <= 1'b0;
            prev_d   <= 1'b0;
        end else begin
            prev_w <= key_w;
            prev_a <= key_a;
            prev_s <= key_s;
            prev_d <= key_d;
            if (!running) begin
                player_x <= game_pkg::START_X[game_pkg::COORD_W-1:0];
                player_y <= game_pkg::START_Y[game_pkg::COORD_W-1:0];
            end else begin
                // one step per key press, w is up
                if (key_w && !prev_w && player_y > game_pkg::MARGIN)
                    player_y <= player_y - game_pkg::STEP[game_pkg::COORD_W-1:0];
                if (key_s && !prev_s && player_y < game_pkg::SCREEN_H - game_pkg::MARGIN)
                    player_y <= player_y + game_pkg::STEP[game_pkg::COORD_W-1:0];
                if (key_a && !prev_a && player_x > game_pkg::MARGIN)
                    player_x <= player_x - game_pkg::STEP[game_pkg::COORD_W-1:0];
                if (key_d && !prev_d && player_x < game_pkg::SCREEN_W - game_pkg::MARGIN)
                    player_x <= player_x + game_pkg::STEP[game_pkg::COORD_W-1:0];
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module game_tb -o sim_game
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_game +verilator+error+limit+1000 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
